// ==== rtl/periph_pkg.sv ====
// Address map, field widths and bus types shared by the peripheral front end and its testbench
`default_nettype none

package periph_pkg;

    // Bus widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int PIN_W  = 8;
    localparam int PIN_IDX_W = $clog2(PIN_W);

    // Slot counts and the populated slots
    localparam int NUM_USER   = 16;
    localparam int NUM_SIMPLE = 16;
    localparam logic [3:0] SLOT_GPIO   = 4'd1;
    localparam logic [3:0] SLOT_BYTE_A = 4'd0;
    localparam logic [3:0] SLOT_BYTE_B = 4'd1;

    localparam int NUM_BYTE_REGS = 4;
    localparam int BYTE_IDX_W    = $clog2(NUM_BYTE_REGS);

    // GPIO register offsets inside its 64-byte user slot
    localparam logic [5:0] GPIO_OUT_OFS  = 6'd0;
    localparam logic [5:0] GPIO_IN_OFS   = 6'd4;
    localparam logic [5:0] FUNC_SEL_BASE = 6'd32;
    localparam int FUNC_SEL_W = 6;

    // Same encoding as the core: 11 means no access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_size_t      write_size;
        access_size_t      read_size;
    } bus_req_t;

    typedef struct packed {
        logic       spare;
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

    typedef struct packed {
        logic [NUM_USER-1:0]   user;
        logic [NUM_SIMPLE-1:0] simple;
    } slot_sel_t;

    // Pins come from the GPIO output register after reset
    localparam func_sel_t FUNC_SEL_RESET = '{spare: 1'b0, simple: 1'b0, slot: SLOT_GPIO};

endpackage

`default_nettype wire

// ==== rtl/periph_decode.sv ====
// Address decoder, turns a bus request into one-hot slot selects and muxes the addressed read word
`timescale 1ns/1ps
`default_nettype none

module periph_decode (
    input  periph_pkg::bus_req_t          i_req,
    input  logic [periph_pkg::DATA_W-1:0] i_gpio_rdata,
    input  logic [7:0]                    i_byte_a_rdata,
    input  logic [7:0]                    i_byte_b_rdata,
    output periph_pkg::slot_sel_t         o_sel,
    output logic [periph_pkg::DATA_W-1:0] o_rdata
);

    logic [1:0] region;
    logic [3:0] user_idx;
    logic [3:0] simple_idx;

    assign region     = i_req.addr[periph_pkg::ADDR_W-1 -: 2];
    assign user_idx   = i_req.addr[9:6];
    assign simple_idx = i_req.addr[7:4];

    always_comb begin
        o_sel   = '0;
        o_rdata = '0;
        case (region)
            2'b00, 2'b01: begin
                o_sel.user[user_idx] = 1'b1;
                if (user_idx == periph_pkg::SLOT_GPIO) begin
                    o_rdata = i_gpio_rdata;
                end
            end
            2'b10: begin
                // Byte slots are widened with zeros
                o_sel.simple[simple_idx] = 1'b1;
                if (simple_idx == periph_pkg::SLOT_BYTE_A) begin
                    o_rdata = {{(periph_pkg::DATA_W-8){1'b0}}, i_byte_a_rdata};
                end else if (simple_idx == periph_pkg::SLOT_BYTE_B) begin
                    o_rdata = {{(periph_pkg::DATA_W-8){1'b0}}, i_byte_b_rdata};
                end
            end
            default: begin
                // Upper user region is not populated
                o_sel   = '0;
                o_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/gpio_ctrl.sv ====
// GPIO user slot with the output register, input readback and per-pin function selects
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              i_sel,
    input  periph_pkg::bus_req_t              i_req,
    input  logic [periph_pkg::PIN_W-1:0]      i_pins_in,
    output logic [periph_pkg::DATA_W-1:0]     o_rdata,
    output logic [periph_pkg::PIN_W-1:0]      o_gpio_out,
    output periph_pkg::func_sel_t             o_func_sel [periph_pkg::PIN_W]
);

    logic [5:0]                         ofs;
    logic                               wr;
    logic [5:0]                         fs_ofs;
    logic                               fs_hit;
    logic [periph_pkg::PIN_IDX_W-1:0]   fs_idx;
    logic [periph_pkg::PIN_W-1:0]       gpio_out_q;
    periph_pkg::func_sel_t              func_sel_q [periph_pkg::PIN_W];

    assign ofs = i_req.addr[5:0];
    assign wr  = i_sel && (i_req.write_size != periph_pkg::SIZE_NONE);

    // Function selects sit on a 4-byte stride from the bank base
    assign fs_ofs = ofs - periph_pkg::FUNC_SEL_BASE;
    assign fs_hit = (ofs >= periph_pkg::FUNC_SEL_BASE) && (fs_ofs[1:0] == 2'b00) &&
                    (fs_ofs[5:2] < periph_pkg::PIN_W);
    assign fs_idx = fs_ofs[2 +: periph_pkg::PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (wr && (ofs == periph_pkg::GPIO_OUT_OFS)) begin
            gpio_out_q <= i_req.wdata[periph_pkg::PIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < periph_pkg::PIN_W; i++) begin
                func_sel_q[i] <= periph_pkg::FUNC_SEL_RESET;
            end
        end else if (wr && fs_hit) begin
            // Spare top bit is kept as written
            func_sel_q[fs_idx] <= periph_pkg::func_sel_t'(i_req.wdata[periph_pkg::FUNC_SEL_W-1:0]);
        end
    end

    // Readback by offset, the decoder picks this slot
    always_comb begin
        o_rdata = '0;
        if (ofs == periph_pkg::GPIO_OUT_OFS) begin
            o_rdata[periph_pkg::PIN_W-1:0] = gpio_out_q;
        end else if (ofs == periph_pkg::GPIO_IN_OFS) begin
            o_rdata[periph_pkg::PIN_W-1:0] = i_pins_in;
        end else if (fs_hit) begin
            o_rdata[periph_pkg::FUNC_SEL_W-1:0] = func_sel_q[fs_idx];
        end
    end

    assign o_gpio_out = gpio_out_q;
    assign o_func_sel = func_sel_q;

endmodule

`default_nettype wire

// ==== rtl/pin_mux.sv ====
// Output pin mux, each pin takes its bit from the slot named by that pin's function select
`timescale 1ns/1ps
`default_nettype none

module pin_mux (
    input  periph_pkg::func_sel_t         i_func_sel [periph_pkg::PIN_W],
    input  logic [periph_pkg::PIN_W-1:0]  i_gpio_out,
    input  logic [periph_pkg::PIN_W-1:0]  i_byte_a_pins,
    input  logic [periph_pkg::PIN_W-1:0]  i_byte_b_pins,
    output logic [periph_pkg::PIN_W-1:0]  o_pins
);

    always_comb begin
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            o_pins[i] = 1'b0;
            if (i_func_sel[i].simple) begin
                if (i_func_sel[i].slot == periph_pkg::SLOT_BYTE_A) begin
                    o_pins[i] = i_byte_a_pins[i];
                end else if (i_func_sel[i].slot == periph_pkg::SLOT_BYTE_B) begin
                    o_pins[i] = i_byte_b_pins[i];
                end
            end else if (i_func_sel[i].slot == periph_pkg::SLOT_GPIO) begin
                o_pins[i] = i_gpio_out[i];
            end
            // Any other slot is empty and drives zero
        end
    end

endmodule

`default_nettype wire

// ==== rtl/read_capture.sv ====
// Read path register, captures the addressed word and holds it until the core completes the read
`timescale 1ns/1ps
`default_nettype none

module read_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  periph_pkg::bus_req_t          i_req,
    input  logic [periph_pkg::DATA_W-1:0] i_rdata,
    input  logic                          i_read_complete,
    output logic [periph_pkg::DATA_W-1:0] o_rdata,
    output logic                          o_ready
);

    logic                          rd;
    logic                          wr;
    logic                          hold_q;
    logic                          ready_q;
    logic [periph_pkg::DATA_W-1:0] rdata_q;

    assign rd = (i_req.read_size != periph_pkg::SIZE_NONE);
    assign wr = (i_req.write_size != periph_pkg::SIZE_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            // Capture wins over complete only when nothing is held
            if (!hold_q && rd) begin
                hold_q <= 1'b1;
            end
            ready_q <= rd;
        end
    end

    // Data register, loaded on the same condition that sets the hold flag
    always_ff @(posedge clk) begin
        if (!hold_q && rd) begin
            rdata_q <= i_rdata;
        end
    end

    assign o_rdata = rdata_q;

    // Writes never stall, reads are ready from the cycle after the request
    assign o_ready = (ready_q && rd) || wr;

endmodule

`default_nettype wire

// ==== rtl/byte_reg_block.sv ====
// Simple-slot peripheral with four byte registers, register 0 drives the pins
`timescale 1ns/1ps
`default_nettype none

module byte_reg_block (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         i_write,
    input  logic [3:0]                   i_offset,
    input  logic [7:0]                   i_wdata,
    output logic [7:0]                   o_rdata,
    output logic [periph_pkg::PIN_W-1:0] o_pins
);

    logic                              in_range;
    logic [periph_pkg::BYTE_IDX_W-1:0] idx;
    logic [7:0]                        regs_q [periph_pkg::NUM_BYTE_REGS];

    assign in_range = (i_offset < periph_pkg::NUM_BYTE_REGS);
    assign idx      = i_offset[periph_pkg::BYTE_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < periph_pkg::NUM_BYTE_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_write && in_range) begin
            regs_q[idx] <= i_wdata;
        end
    end

    // Offsets past the register file read zero
    always_comb begin
        o_rdata = '0;
        if (in_range) begin
            o_rdata = regs_q[idx];
        end
    end

    assign o_pins = regs_q[0];

endmodule

`default_nettype wire

// ==== rtl/periph_top.sv ====
// Peripheral front end top level, joins decode, GPIO, byte blocks, pin mux and the read path
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  periph_pkg::bus_req_t          i_req,
    input  logic                          i_read_complete,
    input  logic [periph_pkg::PIN_W-1:0]  i_pins_in,
    output logic [periph_pkg::DATA_W-1:0] o_rdata,
    output logic                          o_ready,
    output logic [periph_pkg::PIN_W-1:0]  o_pins
);

    periph_pkg::slot_sel_t         sel;
    logic [periph_pkg::DATA_W-1:0] gpio_rdata;
    logic [periph_pkg::DATA_W-1:0] slot_rdata;
    logic [7:0]                    byte_a_rdata;
    logic [7:0]                    byte_b_rdata;
    logic [periph_pkg::PIN_W-1:0]  gpio_out;
    logic [periph_pkg::PIN_W-1:0]  byte_a_pins;
    logic [periph_pkg::PIN_W-1:0]  byte_b_pins;
    periph_pkg::func_sel_t         func_sel [periph_pkg::PIN_W];
    logic                          wr;
    logic                          byte_a_wr;
    logic                          byte_b_wr;

    // Byte slots take the low data byte whatever the write size
    assign wr        = (i_req.write_size != periph_pkg::SIZE_NONE);
    assign byte_a_wr = wr && sel.simple[periph_pkg::SLOT_BYTE_A];
    assign byte_b_wr = wr && sel.simple[periph_pkg::SLOT_BYTE_B];

    periph_decode u_decode (
        .i_req          (i_req),
        .i_gpio_rdata   (gpio_rdata),
        .i_byte_a_rdata (byte_a_rdata),
        .i_byte_b_rdata (byte_b_rdata),
        .o_sel          (sel),
        .o_rdata        (slot_rdata)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (sel.user[periph_pkg::SLOT_GPIO]),
        .i_req      (i_req),
        .i_pins_in  (i_pins_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    byte_reg_block u_byte_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (byte_a_wr),
        .i_offset (i_req.addr[3:0]),
        .i_wdata  (i_req.wdata[7:0]),
        .o_rdata  (byte_a_rdata),
        .o_pins   (byte_a_pins)
    );

    byte_reg_block u_byte_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (byte_b_wr),
        .i_offset (i_req.addr[3:0]),
        .i_wdata  (i_req.wdata[7:0]),
        .o_rdata  (byte_b_rdata),
        .o_pins   (byte_b_pins)
    );

    pin_mux u_pin_mux (
        .i_func_sel    (func_sel),
        .i_gpio_out    (gpio_out),
        .i_byte_a_pins (byte_a_pins),
        .i_byte_b_pins (byte_b_pins),
        .o_pins        (o_pins)
    );

    read_capture u_read_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_rdata         (slot_rdata),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
// Free-running clock source for the testbench top, period set by parameter
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 40.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// ==== verification/periph_props.sv ====
// Read path assertions, bound into read_capture to watch the ready and hold behavior
`timescale 1ns/1ps
`default_nettype none

module periph_props (
    input logic        clk,
    input logic        rst_n,
    input logic        i_rd,
    input logic        i_wr,
    input logic        i_hold,
    input logic        i_ready,
    input logic [31:0] i_rdata
);

    // Ready on a read means the addressed word is already held
    ready_on_held_read: assert property (@(posedge clk) disable iff (!rst_n)
        (i_ready && !i_wr) |-> (i_rd && i_hold))
        else $error("Data ready high on a read before the read data was held");

    // A set hold flag blocks the next capture
    held_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(i_hold) |-> $stable(i_rdata))
        else $error("Read data changed while the hold flag was set");

    ready_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !i_ready)
        else $error("Data ready high in the cycle after reset");

endmodule

bind read_capture periph_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_rd    (rd),
    .i_wr    (wr),
    .i_hold  (hold_q),
    .i_ready (o_ready),
    .i_rdata (o_rdata)
);

`default_nettype wire

// ==== verification/periph_tb.sv ====
// Testbench top, drives random bus traffic into periph_top and checks it against a model
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    localparam int  NUM_RANDOM  = 400;
    localparam int  NUM_OPS     = NUM_RANDOM + 9;
    localparam real CLK_NS      = 40.0;
    localparam int  READY_LIMIT = 8;
    localparam periph_pkg::bus_req_t IDLE_REQ = '{addr: '0, wdata: '0,
        write_size: periph_pkg::SIZE_NONE, read_size: periph_pkg::SIZE_NONE};

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t req;
    logic                 read_complete;
    logic [7:0]           pins_in;
    logic [31:0]          rdata;
    logic                 ready;
    logic [7:0]           pins;
    logic [31:0]          lfsr;
    int                   mismatches;
    int                   failures;

    // Model state, function select as {spare, simple, slot}
    logic [7:0]           m_gpio_out;
    logic [5:0]           m_func_sel [8];
    logic [7:0]           m_byte [2][4];

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clk (.o_clk(clk));

    periph_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_read_complete (read_complete),
        .i_pins_in       (pins_in),
        .o_rdata         (rdata),
        .o_ready         (ready),
        .o_pins          (pins)
    );

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic random_size(output periph_pkg::access_size_t s);
        logic [31:0] v;
        take_bits(2, v);
        s = (v[1:0] == 2'b11) ? periph_pkg::SIZE_WORD : periph_pkg::access_size_t'(v[1:0]);
    endtask

    function automatic logic [10:0] gpio_addr(input logic [5:0] ofs);
        return {1'b0, periph_pkg::SLOT_GPIO, ofs};
    endfunction

    function automatic logic [10:0] byte_addr(input logic blk, input logic x8,
                                              input logic [3:0] ofs);
        return {2'b10, x8, 3'b000, blk, ofs};
    endfunction

    function automatic logic [31:0] model_read(input logic [10:0] addr);
        logic [5:0]  ofs;
        logic [31:0] d;
        ofs = addr[5:0];
        d = '0;
        if (!addr[10] && addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (ofs == 6'd0) begin
                d[7:0] = m_gpio_out;
            end else if (ofs == 6'd4) begin
                d[7:0] = pins_in;
            end else if (ofs[5] && ofs[1:0] == 2'b00) begin
                d[5:0] = m_func_sel[ofs[4:2]];
            end
        end else if (addr[10:9] == 2'b10 && addr[7:5] == 3'b000 && addr[3:2] == 2'b00) begin
            d[7:0] = m_byte[addr[4]][addr[1:0]];
        end
        return d;
    endfunction

    function automatic void model_write(input logic [10:0] addr, input logic [31:0] wdata);
        if (!addr[10] && addr[9:6] == periph_pkg::SLOT_GPIO) begin
            if (addr[5:0] == 6'd0) begin
                m_gpio_out = wdata[7:0];
            end else if (addr[5] && addr[1:0] == 2'b00) begin
                m_func_sel[addr[4:2]] = wdata[5:0];
            end
        end else if (addr[10:9] == 2'b10 && addr[7:5] == 3'b000 && addr[3:2] == 2'b00) begin
            m_byte[addr[4]][addr[1:0]] = wdata[7:0];
        end
    endfunction

    function automatic logic [7:0] model_pins();
        logic [7:0] p;
        p = '0;
        for (int i = 0; i < 8; i++) begin
            if (m_func_sel[i][4] && m_func_sel[i][3:0] < 4'd2) begin
                p[i] = m_byte[m_func_sel[i][0]][0][i];
            end else if (!m_func_sel[i][4] && m_func_sel[i][3:0] == periph_pkg::SLOT_GPIO) begin
                p[i] = m_gpio_out[i];
            end
        end
        return p;
    endfunction

    task automatic check_pins();
        assert (pins === model_pins()) else begin
            mismatches++;
            $display("Mismatch at %0t: pins %h, expected %h", $time, pins, model_pins());
        end
    endtask

    task automatic check_rdata(input logic [10:0] addr, input logic [31:0] exp);
        assert (rdata === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: read of %h gave %h, expected %h", $time, addr, rdata, exp);
        end
    endtask

    task automatic do_write(input logic [10:0] addr, input logic [31:0] wdata,
                            input periph_pkg::access_size_t size);
        @(posedge clk);
        #1;
        req = '{addr: addr, wdata: wdata, write_size: size, read_size: periph_pkg::SIZE_NONE};
        @(negedge clk);
        assert (ready === 1'b1) else begin
            failures++;
            $display("Write to %h at %0t was not acknowledged by data ready", addr, $time);
        end
        @(posedge clk);
        #1;
        req = IDLE_REQ;
        model_write(addr, wdata);
        @(negedge clk);
        check_pins();
    endtask

    // Pins_in is changed on every hold cycle while the read stays present
    task automatic do_read(input logic [10:0] addr, input periph_pkg::access_size_t size,
                           input logic [7:0] pins_val, input int hold_cycles);
        logic [31:0] exp;
        logic [31:0] v;
        int          waited;
        @(posedge clk);
        #1;
        req = '{addr: addr, wdata: '0, write_size: periph_pkg::SIZE_NONE, read_size: size};
        pins_in = pins_val;
        exp = model_read(addr);
        @(negedge clk);
        waited = 0;
        while (ready !== 1'b1 && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (waited == 1) else begin
            failures++;
            $display("Read of %h at %0t: data ready came after %0d cycles instead of one",
                     addr, $time, waited);
        end
        check_rdata(addr, exp);
        for (int i = 0; i < hold_cycles; i++) begin
            @(posedge clk);
            #1;
            take_bits(8, v);
            pins_in = v[7:0];
            @(negedge clk);
            check_rdata(addr, exp);
        end
        @(posedge clk);
        #1;
        req = IDLE_REQ;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    initial begin
        logic [31:0]               op;
        logic [31:0]               data;
        logic [31:0]               pick;
        periph_pkg::access_size_t  size;
        rst_n = 1'b0;
        req = IDLE_REQ;
        read_complete = 1'b0;
        pins_in = '0;
        lfsr = 32'h9d58116a;
        mismatches = 0;
        failures = 0;
        m_gpio_out = '0;
        for (int i = 0; i < 8; i++) begin
            m_func_sel[i] = {2'b00, periph_pkg::SLOT_GPIO};
        end
        for (int b = 0; b < 2; b++) begin
            for (int r = 0; r < 4; r++) begin
                m_byte[b][r] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (ready === 1'b0) else begin
            failures++;
            $display("Data ready was high right after reset at %0t", $time);
        end
        check_pins();
        for (int i = 0; i < 8; i++) begin
            do_read(gpio_addr({1'b1, i[2:0], 2'b00}), periph_pkg::SIZE_WORD, 8'h00, 0);
        end
        do_read(gpio_addr(periph_pkg::GPIO_IN_OFS), periph_pkg::SIZE_WORD, 8'ha5, 4);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(3, op);
            take_bits(32, data);
            take_bits(8, pick);
            random_size(size);
            case (op[2:0])
                3'd0: do_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), data, size);
                3'd1: do_read(gpio_addr(periph_pkg::GPIO_OUT_OFS), size, data[7:0], 0);
                3'd2: do_read(gpio_addr(periph_pkg::GPIO_IN_OFS), size, data[7:0],
                              int'(pick[1:0]));
                3'd3: do_write(gpio_addr({1'b1, pick[2:0], 2'b00}),
                               {data[31:6], pick[7:6], 2'b00, pick[5:4]}, size);
                3'd4: do_read(gpio_addr({1'b1, pick[2:0], 2'b00}), size, data[7:0], 0);
                3'd5: do_write(byte_addr(pick[0], pick[1], pick[7:4]), data, size);
                3'd6: do_read(byte_addr(pick[0], pick[1], pick[7:4]), size, data[7:0], 0);
                default: begin
                    // Anywhere in the map, including empty slots and the upper region
                    if (pick[0]) begin
                        do_write(data[10:0], data, size);
                    end else begin
                        do_read(data[10:0], size, data[31:24], 0);
                    end
                end
            endcase
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(NUM_OPS * 10 * CLK_NS);
        $display("Watchdog expired at %0t before all operations completed", $time);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/periph_pkg.sv
rtl/periph_decode.sv
rtl/gpio_ctrl.sv
rtl/pin_mux.sv
rtl/read_capture.sv
rtl/byte_reg_block.sv
rtl/periph_top.sv
verification/tb_clock.sv
verification/periph_props.sv
verification/periph_tb.sv

// ==== Makefile ====
# Verilator build and run for the peripheral front end testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
